// File: design/regs_defs.svh
// Register file sizes and options
`ifndef REGS_DEFS_SVH
`define REGS_DEFS_SVH

`default_nettype none

// Number of register bytes held in flip-flops
`define REG_NUM_BYTES 8
// Bus data width and the number of byte lanes in one chunk
`define DATA_WIDTH 32
`define STRB_WIDTH 4
// Bus address width
`define ADDR_WIDTH 8
// Chunks that actually hold register bytes
`define NUM_CHUNKS 2
// Low address bits that are decoded, offsets 8 to 15 fall outside the array
`define REG_ADDR_WIDTH 4

// One bit per byte, a set bit makes the byte read-only from the bus
// Byte 1 and all of chunk 1 are read-only
`define READ_ONLY_MASK 8'hF2
// Reset image, byte 0 in the lowest bits
`define REG_RST_VAL 64'h0706050403020100
// Read data returned on a refused read
`define ERR_DATA 32'hBA5E1E55
// When set, only privileged accesses (prot bit 0) are permitted
`define PRIV_PROT_ONLY 1

`default_nettype wire

`endif

// File: design/regs_pkg.sv
// Register file types
`default_nettype none

package regs_pkg;

  // Bus response code, only the two codes this slave can return
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // One register byte
  typedef logic [7:0] byte_t;

  // Index of a chunk inside the decoded slice
  // Two bits cover all four chunks, including the two that hold no bytes
  typedef logic [1:0] chunk_idx_t;

  // A bus data word
  typedef logic [31:0] data_t;

  // A write strobe, one bit per byte lane
  typedef logic [3:0] strb_t;

endpackage

`default_nettype wire

// File: design/lite_chunk_decode.sv
// Chunk address decoder
`include "regs_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module lite_chunk_decode
  import regs_pkg::*;
(
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  input  logic [2:0]             prot_i,
  output chunk_idx_t             chunk_o,
  output logic                   ok_o
);

  // Number of address bits that select a byte lane inside a chunk
  localparam int LANE_BITS = $clog2(`STRB_WIDTH);

  // Only the low slice of the address is looked at
  // Higher bits select the base of this block and are ignored here
  logic [`REG_ADDR_WIDTH-1:0] reg_addr;
  logic                       in_range;
  logic                       prot_ok;

  assign reg_addr = addr_i[`REG_ADDR_WIDTH-1:0];

  // The byte-lane bits are dropped, what is left is the chunk number
  assign chunk_o = reg_addr[`REG_ADDR_WIDTH-1:LANE_BITS];

  // Chunks 2 and 3 lie inside the slice but hold no register bytes
  assign in_range = (int'(chunk_o) < `NUM_CHUNKS);

  // Privileged access is signalled by prot bit 0
  // The secure bit and the instruction bit do not matter to this block
  assign prot_ok = (`PRIV_PROT_ONLY != 0) ? prot_i[0] : 1'b1;

  assign ok_o = in_range && prot_ok;

endmodule

`default_nettype wire

// File: design/lite_resp_spill.sv
// Two-entry response spill register
`timescale 1ns/1ps
`default_nettype none

module lite_resp_spill #(
  parameter int WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // The main slot drives the output, the spill slot catches one more entry
  // The spill slot is only ever full while the main slot is full too
  logic             main_full_q;
  logic             spill_full_q;
  logic [WIDTH-1:0] main_data_q;
  logic [WIDTH-1:0] spill_data_q;

  logic push;
  logic pop;
  logic main_load;
  logic spill_load;

  // Room depends on registered state only, which cuts the path from ready_i
  assign ready_o = !spill_full_q;
  assign valid_o = main_full_q;
  assign data_o  = main_data_q;

  assign push = valid_i && ready_o;
  assign pop  = main_full_q && ready_i;

  // On a pop the main slot refills from the spill slot first, to keep the order
  assign main_load  = (pop && (spill_full_q || push)) || (push && !main_full_q);
  assign spill_load = push && main_full_q && !pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else if (pop) begin
      // A push cannot meet a full spill slot, so the spill always empties here
      main_full_q  <= spill_full_q || push;
      spill_full_q <= 1'b0;
    end else if (push) begin
      main_full_q  <= 1'b1;
      spill_full_q <= main_full_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_data_q <= spill_full_q ? spill_data_q : data_i;
    end
    if (spill_load) begin
      spill_data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/lite_reg_array.sv
// Register byte array
`include "regs_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module lite_reg_array
  import regs_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Write request, already decoded
  input  logic                             aw_valid_i,
  input  logic                             w_valid_i,
  input  data_t                            w_data_i,
  input  strb_t                            w_strb_i,
  input  chunk_idx_t                       aw_chunk_i,
  input  logic                             aw_ok_i,
  input  logic                             b_room_i,
  output logic                             aw_ready_o,
  output logic                             w_ready_o,
  output logic                             b_push_o,
  output axi_resp_e                        b_resp_o,
  // Read request, already decoded
  input  logic                             ar_valid_i,
  input  chunk_idx_t                       ar_chunk_i,
  input  logic                             ar_ok_i,
  input  logic                             r_room_i,
  output data_t                            r_word_o,
  output axi_resp_e                        r_resp_o,
  // Logic side
  input  byte_t [`REG_NUM_BYTES-1:0]       reg_d_i,
  input  logic  [`REG_NUM_BYTES-1:0]       reg_load_i,
  output byte_t [`REG_NUM_BYTES-1:0]       reg_q_o,
  output logic  [`REG_NUM_BYTES-1:0]       wr_active_o,
  output logic  [`REG_NUM_BYTES-1:0]       rd_active_o
);

  localparam logic  [`REG_NUM_BYTES-1:0] RO_MASK   = `READ_ONLY_MASK;
  localparam byte_t [`REG_NUM_BYTES-1:0] RST_IMAGE = `REG_RST_VAL;

  // Byte b sits in chunk b / STRB_WIDTH on lane b % STRB_WIDTH
  byte_t [`REG_NUM_BYTES-1:0] reg_q;
  byte_t [`REG_NUM_BYTES-1:0] reg_d;

  logic load_hit;
  logic chunk_ro;
  logic stall;
  logic wr_accept;
  logic wr_fire;
  logic rd_fire;

  // Look at the bytes of the addressed write chunk
  // A writable byte that the logic side loads while the write strobes it is a conflict
  // The chunk counts as read-only when none of its bytes is writable
  always_comb begin
    load_hit = 1'b0;
    chunk_ro = 1'b1;
    for (int b = 0; b < `REG_NUM_BYTES; b++) begin
      if (int'(aw_chunk_i) == b / `STRB_WIDTH) begin
        if (!RO_MASK[b]) begin
          chunk_ro = 1'b0;
          if (reg_load_i[b] && w_strb_i[b % `STRB_WIDTH]) begin
            load_hit = 1'b1;
          end
        end
      end
    end
  end

  // Refused writes never touch the bytes, so they are never held back
  assign stall = load_hit && aw_ok_i;

  // AW and W are taken together, and only when the B spill has room
  // The B spill ready is registered, so this adds no path from B inputs
  assign wr_accept  = aw_valid_i && w_valid_i && b_room_i && !stall;
  assign wr_fire    = wr_accept && aw_ok_i;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign b_push_o   = wr_accept;

  // Refused writes and writes into a read-only chunk both get SLVERR
  assign b_resp_o = (aw_ok_i && !chunk_ro) ? RESP_OKAY : RESP_SLVERR;

  // Next value of every byte
  // Logic-side loads go in first, then the bus write lands on writable strobed bytes
  // The stall guarantees the two never aim at the same writable byte
  always_comb begin
    reg_d       = reg_q;
    wr_active_o = '0;
    for (int b = 0; b < `REG_NUM_BYTES; b++) begin
      if (reg_load_i[b]) begin
        reg_d[b] = reg_d_i[b];
      end
      if (wr_fire && (int'(aw_chunk_i) == b / `STRB_WIDTH)) begin
        // Reported even for read-only bytes, so the logic side sees the attempt
        wr_active_o[b] = w_strb_i[b % `STRB_WIDTH];
        if (w_strb_i[b % `STRB_WIDTH] && !RO_MASK[b]) begin
          reg_d[b] = w_data_i[8*(b % `STRB_WIDTH) +: 8];
        end
      end
    end
  end

  // The register bytes themselves
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_q <= RST_IMAGE;
    end else begin
      reg_q <= reg_d;
    end
  end

  assign reg_q_o = reg_q;

  // AR transfers when the R spill has room
  assign rd_fire = ar_valid_i && r_room_i;

  // Read mux, the spill captures this word at the AR transfer
  // A refused read returns the error word
  always_comb begin
    rd_active_o = '0;
    r_word_o    = `ERR_DATA;
    r_resp_o    = RESP_SLVERR;
    if (ar_ok_i) begin
      r_word_o = '0;
      r_resp_o = RESP_OKAY;
      for (int b = 0; b < `REG_NUM_BYTES; b++) begin
        if (int'(ar_chunk_i) == b / `STRB_WIDTH) begin
          r_word_o[8*(b % `STRB_WIDTH) +: 8] = reg_q[b];
          rd_active_o[b]                     = rd_fire;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/axi_lite_regs.sv
// AXI4-Lite register file
`include "regs_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs
  import regs_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  // AW channel
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`ADDR_WIDTH-1:0]      aw_addr_i,
  input  logic [2:0]                  aw_prot_i,
  // W channel
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  data_t                       w_data_i,
  input  strb_t                       w_strb_i,
  // B channel
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output axi_resp_e                   b_resp_o,
  // AR channel
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`ADDR_WIDTH-1:0]      ar_addr_i,
  input  logic [2:0]                  ar_prot_i,
  // R channel
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output data_t                       r_data_o,
  output axi_resp_e                   r_resp_o,
  // Logic side
  input  byte_t [`REG_NUM_BYTES-1:0]  reg_d_i,
  input  logic  [`REG_NUM_BYTES-1:0]  reg_load_i,
  output byte_t [`REG_NUM_BYTES-1:0]  reg_q_o,
  output logic  [`REG_NUM_BYTES-1:0]  wr_active_o,
  output logic  [`REG_NUM_BYTES-1:0]  rd_active_o
);

  localparam int B_WIDTH = $bits(axi_resp_e);
  localparam int R_WIDTH = `DATA_WIDTH + $bits(axi_resp_e);

  chunk_idx_t aw_chunk;
  chunk_idx_t ar_chunk;
  logic       aw_ok;
  logic       ar_ok;

  logic       b_push;
  logic       b_room;
  axi_resp_e  b_resp;
  data_t      r_word;
  axi_resp_e  r_resp;

  // Spill outputs, split back into the response fields
  logic [B_WIDTH-1:0] b_spill_q;
  logic [R_WIDTH-1:0] r_spill_q;

  lite_chunk_decode u_aw_dec (
    .addr_i  (aw_addr_i),
    .prot_i  (aw_prot_i),
    .chunk_o (aw_chunk),
    .ok_o    (aw_ok)
  );

  lite_chunk_decode u_ar_dec (
    .addr_i  (ar_addr_i),
    .prot_i  (ar_prot_i),
    .chunk_o (ar_chunk),
    .ok_o    (ar_ok)
  );

  lite_reg_array u_array (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .aw_valid_i  (aw_valid_i),
    .w_valid_i   (w_valid_i),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .aw_chunk_i  (aw_chunk),
    .aw_ok_i     (aw_ok),
    .b_room_i    (b_room),
    .aw_ready_o  (aw_ready_o),
    .w_ready_o   (w_ready_o),
    .b_push_o    (b_push),
    .b_resp_o    (b_resp),
    .ar_valid_i  (ar_valid_i),
    .ar_chunk_i  (ar_chunk),
    .ar_ok_i     (ar_ok),
    .r_room_i    (ar_ready_o),
    .r_word_o    (r_word),
    .r_resp_o    (r_resp),
    .reg_d_i     (reg_d_i),
    .reg_load_i  (reg_load_i),
    .reg_q_o     (reg_q_o),
    .wr_active_o (wr_active_o),
    .rd_active_o (rd_active_o)
  );

  // Write responses, one cycle behind the accepted write
  lite_resp_spill #(
    .WIDTH (B_WIDTH)
  ) u_b_spill (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (b_push),
    .ready_o (b_room),
    .data_i  (b_resp),
    .valid_o (b_valid_o),
    .ready_i (b_ready_i),
    .data_o  (b_spill_q)
  );

  // Read responses, AR valid feeds the spill and the spill room is AR ready
  lite_resp_spill #(
    .WIDTH (R_WIDTH)
  ) u_r_spill (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (ar_valid_i),
    .ready_o (ar_ready_o),
    .data_i  ({r_resp, r_word}),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i),
    .data_o  (r_spill_q)
  );

  assign b_resp_o = axi_resp_e'(b_spill_q);
  assign r_data_o = r_spill_q[`DATA_WIDTH-1:0];
  assign r_resp_o = axi_resp_e'(r_spill_q[R_WIDTH-1:`DATA_WIDTH]);

endmodule

`default_nettype wire

// File: testbench/axi_lite_regs_props.sv
// Register file bus properties
`include "regs_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs_props
  import regs_pkg::*;
(
  input wire logic                        clk_i,
  input wire logic                        rst_i,
  input wire logic                        aw_ready_o,
  input wire logic                        w_ready_o,
  input wire logic                        b_valid_o,
  input wire logic                        b_ready_i,
  input wire axi_resp_e                   b_resp_o,
  input wire logic                        r_valid_o,
  input wire logic                        r_ready_i,
  input wire data_t                       r_data_o,
  input wire axi_resp_e                   r_resp_o,
  input wire logic  [`REG_NUM_BYTES-1:0]  reg_load_i,
  input wire byte_t [`REG_NUM_BYTES-1:0]  reg_q_o
);

  localparam logic [`REG_NUM_BYTES-1:0] RO_MASK = `READ_ONLY_MASK;

  // Assertion failures seen so far
  int unsigned fail_count = 0;

  // A waiting write response keeps its valid and its code until it is taken
  b_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else begin
      fail_count++;
      $error("B response dropped or changed before the handshake");
    end

  // A waiting read response keeps its valid, its data and its code until it is taken
  r_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else begin
      fail_count++;
      $error("R response dropped or changed before the handshake");
    end

  // AW and W are always taken in the same cycle
  aw_w_pair : assert property (@(posedge clk_i) disable iff (rst_i)
    aw_ready_o == w_ready_o)
    else begin
      fail_count++;
      $error("AW and W ready differ");
    end

  // The bus can never change a read-only byte, only a load can
  for (genvar b = 0; b < `REG_NUM_BYTES; b++) begin : g_ro
    if (RO_MASK[b]) begin : g_chk
      ro_keep : assert property (@(posedge clk_i) disable iff (rst_i)
        !reg_load_i[b] |=> $stable(reg_q_o[b]))
        else begin
          fail_count++;
          $error("Read-only byte %0d changed without a load", b);
        end
    end
  end

endmodule

bind axi_lite_regs axi_lite_regs_props u_props (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .aw_ready_o (aw_ready_o),
  .w_ready_o  (w_ready_o),
  .b_valid_o  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_resp_o   (b_resp_o),
  .r_valid_o  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_data_o   (r_data_o),
  .r_resp_o   (r_resp_o),
  .reg_load_i (reg_load_i),
  .reg_q_o    (reg_q_o)
);

`default_nettype wire

// File: testbench/tb_axi_lite_regs.sv
// Register file testbench
`include "regs_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_axi_lite_regs
  import regs_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  // Five behaviors are exercised, each gets its own share of the time limit
  localparam int NUM_STEPS  = 5;
  localparam logic [`REG_NUM_BYTES-1:0] RO_MASK = `READ_ONLY_MASK;
  localparam logic [63:0] RST_VAL = `REG_RST_VAL;

  logic clk_i;
  logic rst_i;
  logic aw_valid_i;
  logic aw_ready_o;
  logic [`ADDR_WIDTH-1:0] aw_addr_i;
  logic [2:0] aw_prot_i;
  logic w_valid_i;
  logic w_ready_o;
  data_t w_data_i;
  strb_t w_strb_i;
  logic b_valid_o;
  logic b_ready_i;
  axi_resp_e b_resp_o;
  logic ar_valid_i;
  logic ar_ready_o;
  logic [`ADDR_WIDTH-1:0] ar_addr_i;
  logic [2:0] ar_prot_i;
  logic r_valid_o;
  logic r_ready_i;
  data_t r_data_o;
  axi_resp_e r_resp_o;
  byte_t [`REG_NUM_BYTES-1:0] reg_d_i;
  logic [`REG_NUM_BYTES-1:0] reg_load_i;
  byte_t [`REG_NUM_BYTES-1:0] reg_q_o;
  logic [`REG_NUM_BYTES-1:0] wr_active_o;
  logic [`REG_NUM_BYTES-1:0] rd_active_o;

  // Reference copy of the bytes and the responses still owed by the DUT
  byte_t model [`REG_NUM_BYTES];
  axi_resp_e exp_b_q [$];
  logic [33:0] exp_r_q [$];
  int errors;
  integer seed;

  axi_lite_regs dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    repeat (200 * NUM_STEPS) @(posedge clk_i);
    $display("Timeout: a bus handshake never completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("Fail %s: got %0h, expected %0h", name, got, exp);
  endtask

  // An access is permitted inside the populated chunks and with prot bit 0 set
  function automatic logic addr_ok(input logic [7:0] addr, input logic [2:0] prot);
    return (int'(addr[3:2]) < `NUM_CHUNKS) && (prot[0] || (`PRIV_PROT_ONLY == 0));
  endfunction

  // SLVERR for refused writes and for chunks with no writable byte
  function automatic axi_resp_e write_resp(input logic [7:0] addr, input logic [2:0] prot);
    logic [3:0] ro;
    ro = 4'(RO_MASK >> (4 * addr[3:2]));
    return (addr_ok(addr, prot) && (ro != 4'hF)) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  // The response code sits above the 32 bits of read data
  function automatic logic [33:0] read_resp(input logic [7:0] addr, input logic [2:0] prot);
    data_t word;
    word = `ERR_DATA;
    if (!addr_ok(addr, prot)) begin
      return {RESP_SLVERR, word};
    end
    for (int k = 0; k < 4; k++) begin
      word[8*k +: 8] = model[4*addr[3:2] + k];
    end
    return {RESP_OKAY, word};
  endfunction

  task automatic check_regs();
    for (int b = 0; b < `REG_NUM_BYTES; b++) begin
      assert (reg_q_o[b] == model[b]) else report_mismatch("reg_q_o", reg_q_o[b], model[b]);
    end
  endtask

  task automatic start_write(input logic [7:0] addr, input logic [2:0] prot,
                             input data_t data, input strb_t strb);
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_prot_i  = prot;
    w_valid_i  = 1'b1;
    w_data_i   = data;
    w_strb_i   = strb;
  endtask

  // Waits for the write to be taken, then folds it into the model
  task automatic finish_write();
    logic [7:0] exp_act;
    logic [1:0] chunk;
    #1;
    while (!aw_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    chunk   = aw_addr_i[3:2];
    exp_act = '0;
    if (addr_ok(aw_addr_i, aw_prot_i)) begin
      exp_act = 8'(w_strb_i) << (4 * chunk);
      for (int k = 0; k < 4; k++) begin
        if (w_strb_i[k] && !RO_MASK[4*chunk + k]) begin
          model[4*chunk + k] = w_data_i[8*k +: 8];
        end
      end
    end
    assert (wr_active_o == exp_act) else report_mismatch("wr_active_o", wr_active_o, exp_act);
    exp_b_q.push_back(write_resp(aw_addr_i, aw_prot_i));
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    check_regs();
  endtask

  task automatic start_read(input logic [7:0] addr, input logic [2:0] prot);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_prot_i  = prot;
  endtask

  task automatic finish_read();
    logic [7:0] exp_act;
    #1;
    while (!ar_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    exp_act = addr_ok(ar_addr_i, ar_prot_i) ? (8'h0F << (4 * ar_addr_i[3:2])) : 8'h00;
    assert (rd_active_o == exp_act) else report_mismatch("rd_active_o", rd_active_o, exp_act);
    exp_r_q.push_back(read_resp(ar_addr_i, ar_prot_i));
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic collect_b();
    axi_resp_e exp;
    @(negedge clk_i);
    b_ready_i = 1'b1;
    #1;
    while (!b_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    exp = exp_b_q.pop_front();
    assert (b_resp_o == exp) else report_mismatch("b_resp_o", b_resp_o, exp);
    @(negedge clk_i);
    b_ready_i = 1'b0;
  endtask

  task automatic collect_r();
    logic [33:0] exp;
    @(negedge clk_i);
    r_ready_i = 1'b1;
    #1;
    while (!r_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    exp = exp_r_q.pop_front();
    assert (r_data_o == exp[31:0]) else report_mismatch("r_data_o", r_data_o, exp[31:0]);
    assert (r_resp_o == exp[33:32]) else report_mismatch("r_resp_o", r_resp_o, exp[33:32]);
    @(negedge clk_i);
    r_ready_i = 1'b0;
  endtask

  task automatic do_write(input logic [7:0] addr, input logic [2:0] prot,
                          input data_t data, input strb_t strb);
    start_write(addr, prot, data, strb);
    finish_write();
    collect_b();
  endtask

  task automatic do_read(input logic [7:0] addr, input logic [2:0] prot);
    start_read(addr, prot);
    finish_read();
    collect_r();
  endtask

  // With a request held, its ready must stay low for a few cycles
  task automatic expect_no_ready(input string name, ref logic ready);
    repeat (3) begin
      #1;
      assert (!ready) else report_mismatch(name, ready, 1'b0);
      @(negedge clk_i);
    end
  endtask

  initial begin
    seed       = 32'h6ca6f953;
    errors     = 0;
    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_prot_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_prot_i  = '0;
    r_ready_i  = 1'b0;
    reg_d_i    = '0;
    reg_load_i = '0;
    for (int b = 0; b < `REG_NUM_BYTES; b++) begin
      model[b] = RST_VAL[8*b +: 8];
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_regs();

    // Reset image read back over the bus
    do_read(8'h00, 3'b001);
    do_read(8'h04, 3'b001);

    // Random strobed writes to chunk 0, then a write into the read-only chunk
    repeat (8) do_write(8'h00, 3'b001, $random(seed), strb_t'($random(seed)));
    do_read(8'h00, 3'b001);
    do_write(8'h04, 3'b001, $random(seed), 4'hF);
    do_read(8'h04, 3'b001);

    // Out-of-range offsets and unprivileged accesses are refused
    do_write(8'h08, 3'b001, $random(seed), 4'hF);
    do_write(8'h0C, 3'b001, $random(seed), 4'hF);
    do_write(8'h00, 3'b110, $random(seed), 4'hF);
    do_read(8'h08, 3'b001);
    do_read(8'h0C, 3'b001);
    do_read(8'h00, 3'b000);

    // A load reaches even a read-only byte at the next edge
    @(negedge clk_i);
    reg_load_i[5] = 1'b1;
    reg_d_i[5]    = 8'hA5;
    model[5]      = 8'hA5;
    @(negedge clk_i);
    reg_load_i = '0;
    check_regs();

    // A load on byte 0 holds off a bus write that strobes byte 0
    reg_load_i[0] = 1'b1;
    reg_d_i[0]    = 8'h3C;
    model[0]      = 8'h3C;
    start_write(8'h00, 3'b001, 32'h11223344, 4'b0001);
    expect_no_ready("aw_ready_o", aw_ready_o);
    reg_load_i = '0;
    finish_write();
    collect_b();

    // Two writes fill the B spill, the third waits until B drains
    start_write(8'h00, 3'b001, $random(seed), 4'hF);
    finish_write();
    start_write(8'h04, 3'b001, $random(seed), 4'hF);
    finish_write();
    start_write(8'h08, 3'b001, $random(seed), 4'hF);
    expect_no_ready("aw_ready_o", aw_ready_o);
    fork
      finish_write();
      repeat (3) collect_b();
    join

    // Same for reads through the R spill
    start_read(8'h00, 3'b001);
    finish_read();
    start_read(8'h04, 3'b001);
    finish_read();
    start_read(8'h0C, 3'b001);
    expect_no_ready("ar_ready_o", ar_ready_o);
    fork
      finish_read();
      repeat (3) collect_r();
    join

    // Failures of the bound properties count as errors too
    errors += dut_i.u_props.fail_count;
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_lite_regs.f
+incdir+design
design/regs_pkg.sv
design/lite_chunk_decode.sv
design/lite_resp_spill.sv
design/lite_reg_array.sv
design/axi_lite_regs.sv
testbench/axi_lite_regs_props.sv
testbench/tb_axi_lite_regs.sv
